/* verilog/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [1:0] lc3b_sel;

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_jmp = 4'b1100,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [4:0] imm5; // low three bits double as sr2
	} lc3b_arith_t;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr; // source register for STR
		lc3b_reg base_r;
		logic [5:0] offset6;
	} lc3b_mem_t;

	typedef struct packed {
		lc3b_opcode opcode;
		logic [2:0] nzp;
		logic [8:0] offset9;
	} lc3b_pcrel_t;

	typedef union packed {
		lc3b_arith_t arith;
		lc3b_mem_t mem;
		lc3b_pcrel_t pcrel;
	} lc3b_instr;

	localparam lc3b_word reset_pc = 16'h0000; // first fetch address

	// mux select encodings shared by controller and datapath
	localparam lc3b_sel pcmux_plus2 = 2'b00;
	localparam lc3b_sel pcmux_offset9 = 2'b01;
	localparam lc3b_sel pcmux_alu = 2'b10;
	localparam lc3b_sel alumux_sr2 = 2'b00;
	localparam lc3b_sel alumux_offset6 = 2'b01;
	localparam lc3b_sel alumux_imm5 = 2'b10;
	localparam lc3b_sel regfilemux_alu = 2'b00;
	localparam lc3b_sel regfilemux_mdr = 2'b01;
	localparam lc3b_sel regfilemux_lea = 2'b10;
	localparam lc3b_sel marmux_alu = 2'b00;
	localparam lc3b_sel marmux_pc = 2'b01;
	localparam lc3b_sel mdrmux_alu = 2'b00;
	localparam lc3b_sel mdrmux_mem = 2'b01;

endpackage : lc3b_pkg

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu import lc3b_pkg::*; (
	input lc3b_aluop aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);

	always_comb begin
		case (aluop)
			alu_add: begin
				f = a + b;
			end
			alu_and: begin
				f = a & b;
			end
			alu_not: begin
				f = ~a; // b is ignored
			end
			default: begin
				f = a; // pass for STR data and JMP target
			end
		endcase
	end

endmodule : alu

`default_nettype wire

/* verilog/regfile.sv */
`default_nettype none

module regfile import lc3b_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic load,
	input lc3b_reg dest,
	input lc3b_word in_data,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

	lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (load) begin
			regs[dest] <= in_data;
		end
	end

	assign reg_a = regs[src_a]; // reads see the old value during a write
	assign reg_b = regs[src_b];

endmodule : regfile

`default_nettype wire

/* verilog/cpu_datapath.sv */
`default_nettype none

module cpu_datapath import lc3b_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic load_pc,
	input logic load_ir,
	input logic load_regfile,
	input logic load_mar,
	input logic load_mdr,
	input logic load_cc,
	input lc3b_aluop aluop,
	input lc3b_sel pcmux_sel,
	input lc3b_sel alumux_sel,
	input lc3b_sel regfilemux_sel,
	input lc3b_sel marmux_sel,
	input lc3b_sel mdrmux_sel,
	input logic storemux_sel,
	input lc3b_word mem_rdata,
	output lc3b_word mem_address,
	output lc3b_word mem_wdata,
	output lc3b_opcode opcode,
	output logic immediate,
	output logic base_is_r7,
	output logic branch_enable
);

	lc3b_word pc;
	lc3b_word mar;
	lc3b_word mdr;
	lc3b_instr ir;
	logic [2:0] cc; // n, z, p
	logic [2:0] cc_next;
	lc3b_word pc_plus2;
	lc3b_word pc_offset;
	lc3b_word sext_imm5;
	lc3b_word adj6;
	lc3b_word adj9;
	lc3b_word reg_a;
	lc3b_word reg_b;
	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word pcmux_out;
	lc3b_word regfile_in;
	lc3b_word marmux_out;
	lc3b_word mdrmux_out;
	lc3b_reg src_a;

	assign pc_plus2 = pc + 16'd2;
	assign sext_imm5 = {{11{ir.arith.imm5[4]}}, ir.arith.imm5};
	assign adj6 = {{9{ir.mem.offset6[5]}}, ir.mem.offset6, 1'b0}; // word offset
	assign adj9 = {{6{ir.pcrel.offset9[8]}}, ir.pcrel.offset9, 1'b0};
	assign pc_offset = pc + adj9; // pc already points past this instruction
	assign src_a = storemux_sel ? ir.mem.dr : ir.arith.sr1; // STR reads its source from dr

	always_comb begin
		case (pcmux_sel)
			pcmux_offset9: pcmux_out = pc_offset;
			pcmux_alu: pcmux_out = alu_out;
			default: pcmux_out = pc_plus2;
		endcase
		case (alumux_sel)
			alumux_offset6: alu_b = adj6;
			alumux_imm5: alu_b = sext_imm5;
			default: alu_b = reg_b;
		endcase
		case (regfilemux_sel)
			regfilemux_mdr: regfile_in = mdr;
			regfilemux_lea: regfile_in = pc_offset;
			default: regfile_in = alu_out;
		endcase
		marmux_out = (marmux_sel == marmux_pc) ? pc : alu_out;
		mdrmux_out = (mdrmux_sel == mdrmux_mem) ? mem_rdata : alu_out;
	end

	always_comb begin
		if (regfile_in[15]) begin
			cc_next = 3'b100;
		end else if (regfile_in == '0) begin
			cc_next = 3'b010;
		end else begin
			cc_next = 3'b001;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
			ir <= '0;
			mar <= '0;
			mdr <= '0;
			cc <= '0;
		end else begin
			if (load_pc) pc <= pcmux_out;
			if (load_ir) ir <= mdr;
			if (load_mar) mar <= marmux_out;
			if (load_mdr) mdr <= mdrmux_out;
			if (load_cc) cc <= cc_next;
		end
	end

	regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.load(load_regfile),
		.dest(ir.arith.dr),
		.in_data(regfile_in),
		.src_a(src_a),
		.src_b(ir.arith.imm5[2:0]), // sr2 field
		.reg_a(reg_a),
		.reg_b(reg_b)
	);

	alu u_alu (
		.aluop(aluop),
		.a(reg_a),
		.b(alu_b),
		.f(alu_out)
	);

	assign mem_address = mar;
	assign mem_wdata = mdr;
	assign opcode = ir.arith.opcode;
	assign immediate = ir.arith.imm_flag;
	assign base_is_r7 = (ir.mem.base_r == 3'b111);
	assign branch_enable = |(ir.pcrel.nzp & cc);

endmodule : cpu_datapath

`default_nettype wire

/* verilog/cpu_control.sv */
`default_nettype none

module cpu_control import lc3b_pkg::*; (
	input logic clk,
	input logic rst_n,
	input lc3b_opcode opcode,
	input logic immediate,
	input logic base_is_r7,
	input logic branch_enable,
	input logic mem_resp,
	output logic load_pc,
	output logic load_ir,
	output logic load_regfile,
	output logic load_mar,
	output logic load_mdr,
	output logic load_cc,
	output lc3b_aluop aluop,
	output lc3b_sel pcmux_sel,
	output lc3b_sel alumux_sel,
	output lc3b_sel regfilemux_sel,
	output lc3b_sel marmux_sel,
	output lc3b_sel mdrmux_sel,
	output logic storemux_sel,
	output logic mem_read,
	output logic mem_write
);

	enum logic [4:0] {
		fetch1, fetch2, fetch3, decode,
		s_add, s_and, s_not,
		s_calc_addr, s_ldr1, s_ldr2, s_str1, s_str2,
		s_br, s_br_taken, s_jmp, s_ret, s_lea
	} state, next_state;

	always_comb begin
		load_pc = 1'b0;
		load_ir = 1'b0;
		load_regfile = 1'b0;
		load_mar = 1'b0;
		load_mdr = 1'b0;
		load_cc = 1'b0;
		aluop = alu_add;
		pcmux_sel = pcmux_plus2;
		alumux_sel = alumux_sr2;
		regfilemux_sel = regfilemux_alu;
		marmux_sel = marmux_alu;
		mdrmux_sel = mdrmux_alu;
		storemux_sel = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		case (state)
			fetch1: begin
				marmux_sel = marmux_pc; // mar <= pc, pc <= pc + 2
				load_mar = 1'b1;
				load_pc = 1'b1;
			end
			fetch2: begin
				mem_read = 1'b1;
				mdrmux_sel = mdrmux_mem;
				load_mdr = mem_resp; // capture only the response word
			end
			fetch3: begin
				load_ir = 1'b1;
			end
			s_add, s_and: begin
				aluop = (state == s_add) ? alu_add : alu_and;
				alumux_sel = immediate ? alumux_imm5 : alumux_sr2;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			s_not: begin
				aluop = alu_not;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			s_calc_addr: begin
				alumux_sel = alumux_offset6; // base + offset6 * 2
				load_mar = 1'b1;
			end
			s_ldr1: begin
				mem_read = 1'b1;
				mdrmux_sel = mdrmux_mem;
				load_mdr = mem_resp;
			end
			s_ldr2: begin
				regfilemux_sel = regfilemux_mdr;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			s_str1: begin
				storemux_sel = 1'b1; // store data comes from dr
				aluop = alu_pass;
				load_mdr = 1'b1;
			end
			s_str2: begin
				mem_write = 1'b1;
			end
			s_br_taken: begin
				pcmux_sel = pcmux_offset9;
				load_pc = 1'b1;
			end
			s_jmp, s_ret: begin
				aluop = alu_pass; // base register straight to pc
				pcmux_sel = pcmux_alu;
				load_pc = 1'b1;
			end
			s_lea: begin
				regfilemux_sel = regfilemux_lea;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			default: ; // decode and s_br only look at the IR
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			fetch1: next_state = fetch2;
			fetch2: if (mem_resp) next_state = fetch3;
			fetch3: next_state = decode;
			decode: begin
				case (opcode)
					op_add: next_state = s_add;
					op_and: next_state = s_and;
					op_not: next_state = s_not;
					op_ldr, op_str: next_state = s_calc_addr;
					op_br: next_state = s_br;
					op_jmp: next_state = base_is_r7 ? s_ret : s_jmp;
					op_lea: next_state = s_lea;
					default: next_state = fetch1; // unsupported opcode is skipped
				endcase
			end
			s_calc_addr: next_state = (opcode == op_ldr) ? s_ldr1 : s_str1;
			s_ldr1: if (mem_resp) next_state = s_ldr2;
			s_str1: next_state = s_str2;
			s_str2: if (mem_resp) next_state = fetch1;
			s_br: next_state = branch_enable ? s_br_taken : fetch1;
			default: next_state = fetch1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= fetch1;
		end else begin
			state <= next_state;
		end
	end

endmodule : cpu_control

`default_nettype wire

/* verilog/cpu.sv */
`default_nettype none

module cpu import lc3b_pkg::*; (
	input logic clk,
	input logic rst_n,
	input lc3b_word mem_rdata,
	input logic mem_resp,
	output lc3b_word mem_address,
	output lc3b_word mem_wdata,
	output logic mem_read,
	output logic mem_write
);

	logic load_pc;
	logic load_ir;
	logic load_regfile;
	logic load_mar;
	logic load_mdr;
	logic load_cc;
	lc3b_aluop aluop;
	lc3b_sel pcmux_sel;
	lc3b_sel alumux_sel;
	lc3b_sel regfilemux_sel;
	lc3b_sel marmux_sel;
	lc3b_sel mdrmux_sel;
	logic storemux_sel;
	lc3b_opcode opcode;
	logic immediate;
	logic base_is_r7;
	logic branch_enable;

	// port names match across both blocks
	cpu_control u_control (.*);

	cpu_datapath u_datapath (.*);

endmodule : cpu

`default_nettype wire

/* tests/cpu_asserts.sv */
`default_nettype none

module cpu_asserts import lc3b_pkg::*; (
	input logic clk,
	input logic rst_n,
	input lc3b_word mem_address,
	input lc3b_word mem_wdata,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned error_count = 0;
	logic seen_request; // set once the first request after reset shows up

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seen_request <= 1'b0;
		end else if (mem_read || mem_write) begin
			seen_request <= 1'b1;
		end
	end

	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write))
		else begin
			error_count++;
			$error("mem_read and mem_write are high together");
		end

	// a held request keeps its kind, address and data until the response
	request_held: assert property (@(posedge clk) disable iff (!rst_n)
		((mem_read || mem_write) && !mem_resp) |=>
		$stable({mem_read, mem_write}) && $stable(mem_address) && $stable(mem_wdata))
		else begin
			error_count++;
			$error("request changed or dropped before mem_resp");
		end

	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !mem_read && !mem_write)
		else begin
			error_count++;
			$error("memory request made during reset");
		end

	first_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		(!seen_request && (mem_read || mem_write)) |-> mem_read && mem_address == reset_pc)
		else begin
			error_count++;
			$error("first request after reset is not a read of the reset pc");
		end

	resp_in_request: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |-> (mem_read || mem_write))
		else begin
			error_count++;
			$error("mem_resp given with no request held");
		end

endmodule : cpu_asserts

bind cpu cpu_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.mem_address(mem_address),
	.mem_wdata(mem_wdata),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_resp(mem_resp)
);

`default_nettype wire

/* tests/cpu_tb.sv */
`default_nettype none

module cpu_tb import lc3b_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_stores = 8;
	localparam int req_timeout = 50; // idle cycles allowed between requests
	localparam int max_requests = 200;
	localparam lc3b_word br_p_addr = 16'h0020;
	localparam lc3b_word br_p_target = 16'h0024;
	localparam lc3b_word jmp_addr = 16'h0028;
	localparam lc3b_word loop_addr = 16'h002E;
	localparam lc3b_word data_limit = 16'h0060; // program lives below the data area

	logic clk;
	logic rst_n;
	lc3b_word mem_rdata;
	logic mem_resp;
	lc3b_word mem_address;
	lc3b_word mem_wdata;
	logic mem_read;
	logic mem_write;

	lc3b_word mem_array [64];
	lc3b_word exp_addr [num_stores];
	lc3b_word exp_data [num_stores];
	int seed;
	int errors;
	int proto_errors;
	int store_idx;
	int loop_hits;
	int requests;
	bit timed_out;
	bit got_request;
	lc3b_word prev_fetch;

	cpu UUT (
		.clk(clk),
		.rst_n(rst_n),
		.mem_rdata(mem_rdata),
		.mem_resp(mem_resp),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_read(mem_read),
		.mem_write(mem_write)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic load_program();
		for (logic [6:0] i = 7'd0; i < 7'd64; i++) begin
			mem_array[i[5:0]] = 16'hA000 | lc3b_word'(i); // unsupported opcode tagged with the word index
		end
		mem_array[0] = 16'h1225; // ADD R1, R0, #5
		mem_array[1] = 16'h1422; // ADD R2, R0, #2
		mem_array[2] = 16'h567E; // AND R3, R1, #-2
		mem_array[3] = 16'h98BF; // NOT R4, R2
		mem_array[4] = 16'h1A44; // ADD R5, R1, R4
		mem_array[5] = 16'hEC2A; // LEA R6, data area
		mem_array[6] = 16'h7380; // STR R1, R6, #0
		mem_array[7] = 16'h7581; // STR R2, R6, #1
		mem_array[8] = 16'h7782; // STR R3, R6, #2
		mem_array[9] = 16'h7983; // STR R4, R6, #3
		mem_array[10] = 16'h7B84; // STR R5, R6, #4
		mem_array[11] = 16'h6F83; // LDR R7, R6, #3
		mem_array[12] = 16'h7F85; // STR R7, R6, #5
		mem_array[13] = 16'h0401; // BRz +1 while cc is n
		mem_array[14] = 16'h7386; // STR R1, R6, #6
		mem_array[15] = 16'h5443; // AND R2, R1, R3
		mem_array[16] = 16'h0201; // BRp +1
		mem_array[17] = 16'h7587; // poisoned STR R2, R6, #7
		mem_array[18] = 16'h7588; // STR R2, R6, #8
		mem_array[19] = 16'hE603; // LEA R3, self loop
		mem_array[20] = 16'hC0C0; // JMP R3
		mem_array[21] = 16'h7389; // poisoned
		mem_array[22] = 16'h7389; // poisoned
		mem_array[23] = 16'h0FFF; // BRnzp to itself
	endtask

	task automatic build_expected();
		lc3b_word r1;
		lc3b_word r2;
		lc3b_word r3;
		lc3b_word r4;
		lc3b_word r5;
		lc3b_word r7;
		lc3b_word r2_and;
		lc3b_word base;
		r1 = 16'd5;
		r2 = 16'd2;
		r3 = r1 & 16'hFFFE; // imm5 of -2 sign-extends
		r4 = ~r2;
		r5 = r1 + r4;
		r7 = r4; // reloaded from the slot written by R4
		r2_and = r1 & r3;
		base = 16'h000C + (16'd42 << 1); // next pc plus doubled offset9
		exp_addr[0] = base;
		exp_data[0] = r1;
		exp_addr[1] = base + 16'd2;
		exp_data[1] = r2;
		exp_addr[2] = base + 16'd4;
		exp_data[2] = r3;
		exp_addr[3] = base + 16'd6;
		exp_data[3] = r4;
		exp_addr[4] = base + 16'd8;
		exp_data[4] = r5;
		exp_addr[5] = base + 16'd10;
		exp_data[5] = r7;
		exp_addr[6] = base + 16'd12; // only reached when BRz falls through
		exp_data[6] = r1;
		exp_addr[7] = base + 16'd16;
		exp_data[7] = r2_and;
	endtask

	task automatic check_store(input lc3b_word addr, input lc3b_word data);
		if (store_idx >= num_stores) begin
			errors++;
			$display("unexpected store to address 0x%h after all expected stores", addr);
		end else begin
			if (addr !== exp_addr[store_idx[2:0]]) begin
				errors++;
				$display("** Error: mem_address of store %0d expected 0x%h, got 0x%h",
					store_idx, exp_addr[store_idx[2:0]], addr);
			end
			if (data !== exp_data[store_idx[2:0]]) begin
				errors++;
				$display("** Error: mem_wdata of store %0d expected 0x%h, got 0x%h",
					store_idx, exp_data[store_idx[2:0]], data);
			end
		end
		store_idx++;
	endtask

	task automatic note_fetch(input lc3b_word addr);
		if (addr < data_limit) begin
			if (prev_fetch == br_p_addr && addr !== br_p_target) begin
				errors++;
				$display("** Error: mem_address after taken branch expected 0x%h, got 0x%h",
					br_p_target, addr);
			end
			if (prev_fetch == jmp_addr && addr !== loop_addr) begin
				errors++;
				$display("** Error: mem_address after jump expected 0x%h, got 0x%h",
					loop_addr, addr);
			end
			if (addr == loop_addr) loop_hits++;
			prev_fetch = addr;
		end
	endtask

	task automatic wait_request(output bit found);
		int cycles;
		cycles = 0;
		found = 1'b0;
		while (!found && cycles < req_timeout) begin
			@(posedge clk);
			#1;
			if (mem_read || mem_write) found = 1'b1;
			else cycles++;
		end
	endtask

	task automatic serve_request();
		int delay;
		lc3b_word addr;
		lc3b_word data;
		bit is_write;
		delay = $random(seed) & 3; // 0 to 3 extra cycles
		repeat (delay) begin
			@(posedge clk);
			#1;
		end
		addr = mem_address;
		data = mem_wdata;
		is_write = mem_write;
		mem_rdata = mem_array[addr[6:1]];
		mem_resp = 1'b1;
		@(posedge clk);
		#1;
		mem_resp = 1'b0;
		if (is_write) begin
			mem_array[addr[6:1]] = data;
			check_store(addr, data);
		end else begin
			note_fetch(addr);
		end
	endtask

	initial begin
		seed = 74611;
		errors = 0;
		proto_errors = 0;
		store_idx = 0;
		loop_hits = 0;
		requests = 0;
		timed_out = 1'b0;
		got_request = 1'b0;
		prev_fetch = 16'hFFFF;
		rst_n = 1'b0;
		mem_rdata = '0;
		mem_resp = 1'b0;
		load_program();
		build_expected();
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		while (loop_hits < 2 && !timed_out) begin
			wait_request(got_request);
			if (!got_request) begin
				timed_out = 1'b1;
				$display("timeout: no memory request for %0d cycles", req_timeout);
			end else if (requests >= max_requests) begin
				timed_out = 1'b1;
				$display("timeout: self loop not reached within %0d requests", max_requests);
			end else begin
				requests++;
				serve_request();
			end
		end
		if (store_idx < num_stores) begin
			errors++;
			$display("missing stores: saw %0d of %0d", store_idx, num_stores);
		end
		proto_errors = int'(UUT.u_asserts.error_count);
		$display("errors: %0d store and fetch, %0d protocol, %0d timeout",
			errors, proto_errors, int'(timed_out));
		if (errors == 0 && proto_errors == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule : cpu_tb

`default_nettype wire

/* compile.f */
verilog/lc3b_pkg.sv
verilog/alu.sv
verilog/regfile.sv
verilog/cpu_datapath.sv
verilog/cpu_control.sv
verilog/cpu.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = cpu_tb
FILELIST = compile.f
OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
